/* tb.f */
+incdir+design
design/io_pkg.sv
design/spi_pin_if.sv
design/pad_cell.sv
design/pad_frame.sv
design/spi_master.sv
design/spi_pad_arbiter.sv
design/gpio_ctrl.sv
design/io_top.sv
bench/spi_echo_model.sv
bench/tb_io_top.sv

/* bench/tb_io_top.sv */
// ----------------------------------------------------------------------------
// Testbench for io_top: SPI frames on the shared pads, arbitration and GPIO
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "io_params.svh"

module tb_io_top;

  localparam int BITS       = `IO_SPI_BITS;
  localparam int GPIO_W     = `IO_GPIO_W;
  localparam int RST_CYCLES = 10;
  // Start to done when the pads are free: request, grant, LEAD, shifting
  localparam int LAT        = 3 + BITS * 2 * `IO_SPI_DIV;
  localparam int N_XFER     = 8;
  localparam int CYC_LIMIT  = 40 * N_XFER + 200;

  logic              ref_clk_i;
  logic              rst_n_i;
  logic              boot_start_i;
  logic [BITS-1:0]   boot_tx_i;
  logic [BITS-1:0]   boot_rx_o;
  logic              boot_done_o;
  logic              boot_busy_o;
  logic              host_start_i;
  logic [BITS-1:0]   host_tx_i;
  logic [BITS-1:0]   host_rx_o;
  logic              host_done_o;
  logic              host_busy_o;
  logic [GPIO_W-1:0] gpio_out_i;
  logic [GPIO_W-1:0] gpio_dir_i;
  logic [GPIO_W-1:0] gpio_in_o;
  wire               pad_spim_sck;
  wire               pad_spim_csn0;
  wire               pad_spim_sdio0;
  wire               pad_spim_sdio1;
  wire [GPIO_W-1:0]  pad_gpio;
  logic [BITS-1:0]   echo_last_rx;

  logic [GPIO_W-1:0] gpio_drv;
  logic [GPIO_W-1:0] gpio_drv_en;
  logic [GPIO_W-1:0] pad_hist1;
  logic [GPIO_W-1:0] pad_hist2;

  // Expected SPI results
  logic [BITS-1:0]   boot_tx_hold;
  logic [BITS-1:0]   host_tx_hold;
  logic [BITS-1:0]   prev_frame;
  logic              boot_open;
  logic              host_open;
  logic              pair_active;
  logic              pair_first_done;
  logic              boot_first_exp;
  int                cyc = 0;
  int                errors = 0;
  int                xfers = 0;
  integer            seed;

  initial begin
    ref_clk_i = 1'b0;
    forever #5 ref_clk_i = ~ref_clk_i;
  end

  io_top u_dut (
    .ref_clk_i      (ref_clk_i),
    .rst_n_i        (rst_n_i),
    .boot_start_i   (boot_start_i),
    .boot_tx_i      (boot_tx_i),
    .boot_rx_o      (boot_rx_o),
    .boot_done_o    (boot_done_o),
    .boot_busy_o    (boot_busy_o),
    .host_start_i   (host_start_i),
    .host_tx_i      (host_tx_i),
    .host_rx_o      (host_rx_o),
    .host_done_o    (host_done_o),
    .host_busy_o    (host_busy_o),
    .gpio_out_i     (gpio_out_i),
    .gpio_dir_i     (gpio_dir_i),
    .gpio_in_o      (gpio_in_o),
    .pad_spim_sck   (pad_spim_sck),
    .pad_spim_csn0  (pad_spim_csn0),
    .pad_spim_sdio0 (pad_spim_sdio0),
    .pad_spim_sdio1 (pad_spim_sdio1),
    .pad_gpio       (pad_gpio)
  );

  spi_echo_model u_echo (
    .sck_i     (pad_spim_sck),
    .csn_i     (pad_spim_csn0),
    .mosi_i    (pad_spim_sdio0),
    .miso_o    (pad_spim_sdio1),
    .last_rx_o (echo_last_rx)
  );

  // Bench drive on GPIO pads set as inputs
  genvar g;
  generate
    for (g = 0; g < GPIO_W; g++) begin : g_drv
      assign pad_gpio[g] = gpio_drv_en[g] ? gpio_drv[g] : 1'bz;
    end
  endgenerate

  always @(posedge ref_clk_i) begin
    cyc       <= cyc + 1;
    pad_hist1 <= pad_gpio;
    pad_hist2 <= pad_hist1;
    if (boot_done_o) begin
      prev_frame <= boot_tx_hold;
      boot_open  <= 1'b0;
      xfers      <= xfers + 1;
    end
    if (host_done_o) begin
      prev_frame <= host_tx_hold;
      host_open  <= 1'b0;
      xfers      <= xfers + 1;
    end
  end

  initial begin
    wait (cyc == CYC_LIMIT);
    $display("Run stopped at the cycle limit of %0d, %0d errors so far", CYC_LIMIT, errors);
    $display("Test FAILED");
    $finish;
  end

  task automatic record_error(input string msg);
    errors = errors + 1;
    $display("%s", msg);
  endtask

  task automatic tick();
    @(posedge ref_clk_i);
    #1;
  endtask

  task automatic start_frames(input bit do_boot, input bit do_host);
    if (do_boot) begin
      boot_tx_i    = $random(seed);
      boot_tx_hold = boot_tx_i;
      boot_open    = 1'b1;
      boot_start_i = 1'b1;
    end
    if (do_host) begin
      host_tx_i    = $random(seed);
      host_tx_hold = host_tx_i;
      host_open    = 1'b1;
      host_start_i = 1'b1;
    end
    tick();
    boot_start_i = 1'b0;
    host_start_i = 1'b0;
  endtask

  // Returns one cycle after the done pulse
  task automatic wait_done(input bit of_boot);
    while (!(of_boot ? boot_done_o : host_done_o)) begin
      tick();
    end
    tick();
  endtask

  task automatic run_pair();
    pair_active     = 1'b1;
    pair_first_done = 1'b0;
    start_frames(1'b1, 1'b1);
    while (!boot_done_o && !host_done_o) begin
      tick();
    end
    tick();
    pair_first_done = 1'b1;
    while (!boot_done_o && !host_done_o) begin
      tick();
    end
    tick();
    pair_active    = 1'b0;
    boot_first_exp = !boot_first_exp;
  endtask

  initial begin
    seed            = 80578;
    rst_n_i         = 1'b0;
    boot_start_i    = 1'b0;
    boot_tx_i       = '0;
    host_start_i    = 1'b0;
    host_tx_i       = '0;
    gpio_out_i      = '0;
    gpio_dir_i      = '0;
    gpio_drv        = '0;
    gpio_drv_en     = '0;
    boot_tx_hold    = '0;
    host_tx_hold    = '0;
    prev_frame      = '0;
    boot_open       = 1'b0;
    host_open       = 1'b0;
    pair_active     = 1'b0;
    pair_first_done = 1'b0;
    boot_first_exp  = 1'b1;
    repeat (RST_CYCLES) tick();
    rst_n_i = 1'b1;
    repeat (3) tick();

    // Host alone, first echo byte is 0x00
    start_frames(1'b0, 1'b1);
    wait_done(1'b0);
    start_frames(1'b0, 1'b1);
    wait_done(1'b0);
    // Tied requests, boot wins first, then host
    run_pair();
    run_pair();
    start_frames(1'b1, 1'b0);
    wait_done(1'b1);

    // Second start while busy must be dropped
    start_frames(1'b0, 1'b1);
    repeat (10) tick();
    host_start_i = 1'b1;
    tick();
    host_start_i = 1'b0;
    wait_done(1'b0);
    repeat (50) tick();

    gpio_dir_i = '1;
    gpio_out_i = $random(seed);
    repeat (3) tick();
    gpio_out_i = ~gpio_out_i;
    repeat (3) tick();
    // Upper half as inputs, two driven and two on the pull-up
    gpio_dir_i  = 'h0f;
    gpio_drv_en = 'h30;
    gpio_drv    = 'h10;
    repeat (4) tick();
    gpio_drv = 'h20;
    repeat (4) tick();
    gpio_dir_i  = '0;
    gpio_drv_en = '1;
    gpio_drv    = $random(seed);
    repeat (4) tick();
    gpio_drv_en = '0;
    repeat (4) tick();

    $display("Transfers: %0d  Errors: %0d", xfers, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  a_reset_idle: assert property (@(posedge ref_clk_i) (cyc != 0 && !rst_n_i) |->
    pad_spim_csn0 && !pad_spim_sck && !boot_done_o && !host_done_o &&
    !boot_busy_o && !host_busy_o)
    else record_error($sformatf("FAIL reset: csn0 %h sck %h done %h%h busy %h%h",
      $sampled(pad_spim_csn0), $sampled(pad_spim_sck), $sampled(boot_done_o),
      $sampled(host_done_o), $sampled(boot_busy_o), $sampled(host_busy_o)));

  a_idle_pads: assert property (@(posedge ref_clk_i)
    (rst_n_i && !boot_busy_o && !host_busy_o) |-> pad_spim_csn0 && !pad_spim_sck)
    else record_error($sformatf("FAIL idle pads: pad_spim_csn0 %h pad_spim_sck %h",
      $sampled(pad_spim_csn0), $sampled(pad_spim_sck)));

  a_boot_latency: assert property (@(posedge ref_clk_i)
    (rst_n_i && boot_start_i && !host_start_i && !boot_busy_o && !host_busy_o) |=>
    !boot_done_o [*LAT] ##1 boot_done_o)
    else record_error($sformatf("boot_done_o did not pulse %0d cycles after start", LAT));

  a_host_latency: assert property (@(posedge ref_clk_i)
    (rst_n_i && host_start_i && !boot_start_i && !boot_busy_o && !host_busy_o) |=>
    !host_done_o [*LAT] ##1 host_done_o)
    else record_error($sformatf("host_done_o did not pulse %0d cycles after start", LAT));

  a_boot_echo: assert property (@(posedge ref_clk_i) boot_done_o |-> echo_last_rx == boot_tx_hold)
    else record_error($sformatf("FAIL echo last_rx: got %h, expected %h",
      $sampled(echo_last_rx), $sampled(boot_tx_hold)));

  a_boot_rx: assert property (@(posedge ref_clk_i) boot_done_o |-> boot_rx_o == prev_frame)
    else record_error($sformatf("FAIL boot_rx_o: got %h, expected %h",
      $sampled(boot_rx_o), $sampled(prev_frame)));

  a_host_echo: assert property (@(posedge ref_clk_i) host_done_o |-> echo_last_rx == host_tx_hold)
    else record_error($sformatf("FAIL echo last_rx: got %h, expected %h",
      $sampled(echo_last_rx), $sampled(host_tx_hold)));

  a_host_rx: assert property (@(posedge ref_clk_i) host_done_o |-> host_rx_o == prev_frame)
    else record_error($sformatf("FAIL host_rx_o: got %h, expected %h",
      $sampled(host_rx_o), $sampled(prev_frame)));

  a_boot_open: assert property (@(posedge ref_clk_i) boot_done_o |-> boot_open)
    else record_error("boot_done_o pulsed with no boot transfer pending");

  a_host_open: assert property (@(posedge ref_clk_i) host_done_o |-> host_open)
    else record_error("host_done_o pulsed with no host transfer pending");

  a_pair_boot: assert property (@(posedge ref_clk_i)
    (pair_active && !pair_first_done && boot_done_o) |-> boot_first_exp)
    else record_error("boot engine finished first although host had the turn");

  a_pair_host: assert property (@(posedge ref_clk_i)
    (pair_active && !pair_first_done && host_done_o) |-> !boot_first_exp)
    else record_error("host engine finished first although boot had the turn");

  a_csn_gap: assert property (@(posedge ref_clk_i)
    (boot_done_o || host_done_o) |-> pad_spim_csn0 ##1 pad_spim_csn0)
    else record_error("chip select pad went low right after a frame ended");

  a_gpio_out: assert property (@(posedge ref_clk_i)
    rst_n_i |-> ((pad_gpio ^ gpio_out_i) & gpio_dir_i) == '0)
    else record_error($sformatf("FAIL pad_gpio: got %h, expected %h",
      $sampled(pad_gpio & gpio_dir_i), $sampled(gpio_out_i & gpio_dir_i)));

  a_gpio_pull: assert property (@(posedge ref_clk_i)
    (cyc != 0) |-> (~pad_gpio & ~gpio_dir_i & ~gpio_drv_en) == '0)
    else record_error($sformatf("FAIL pad_gpio pull-up: got %h, undriven mask %h",
      $sampled(pad_gpio), $sampled(~gpio_dir_i & ~gpio_drv_en)));

  a_gpio_sync: assert property (@(posedge ref_clk_i)
    (cyc >= RST_CYCLES + 2) |-> gpio_in_o == pad_hist2)
    else record_error($sformatf("FAIL gpio_in_o: got %h, expected %h",
      $sampled(gpio_in_o), $sampled(pad_hist2)));

endmodule

`default_nettype wire

/* bench/spi_echo_model.sv */
// ----------------------------------------------------------------------------
// SPI slave model, mode 0, sends the previous frame back on MISO
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "io_params.svh"

module spi_echo_model (
  input  wire                     sck_i,
  input  wire                     csn_i,
  input  wire                     mosi_i,
  output logic                    miso_o,
  output logic [`IO_SPI_BITS-1:0] last_rx_o
);

  logic [`IO_SPI_BITS-1:0] rx_sr = '0;
  logic [`IO_SPI_BITS-1:0] tx_sr = '0;
  // Byte returned during the next frame
  logic [`IO_SPI_BITS-1:0] echo_q = '0;

  initial begin
    miso_o    = 1'b0;
    last_rx_o = '0;
  end

  // Frame start, MSB of the echo byte goes out first
  always @(negedge csn_i) begin
    tx_sr  = echo_q;
    miso_o = echo_q[`IO_SPI_BITS-1];
  end

  always @(posedge sck_i) begin
    if (!csn_i) begin
      rx_sr = {rx_sr[`IO_SPI_BITS-2:0], mosi_i};
    end
  end

  // MISO moves on falling SCK
  always @(negedge sck_i) begin
    if (!csn_i) begin
      tx_sr  = {tx_sr[`IO_SPI_BITS-2:0], 1'b0};
      miso_o = tx_sr[`IO_SPI_BITS-1];
    end
  end

  always @(posedge csn_i) begin
    last_rx_o = rx_sr;
    echo_q    = rx_sr;
  end

endmodule

`default_nettype wire

/* design/io_top.sv */
// ----------------------------------------------------------------------------
// I/O subsystem top: two SPI engines on one shared pad set, plus GPIO
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "io_params.svh"

module io_top
  import io_pkg::*;
(
  input  wire                     ref_clk_i,
  input  wire                     rst_n_i,
  // Boot loader engine
  input  wire                     boot_start_i,
  input  wire [`IO_SPI_BITS-1:0]  boot_tx_i,
  output logic [`IO_SPI_BITS-1:0] boot_rx_o,
  output logic                    boot_done_o,
  output logic                    boot_busy_o,
  // Host engine
  input  wire                     host_start_i,
  input  wire [`IO_SPI_BITS-1:0]  host_tx_i,
  output logic [`IO_SPI_BITS-1:0] host_rx_o,
  output logic                    host_done_o,
  output logic                    host_busy_o,
  // GPIO
  input  wire [`IO_GPIO_W-1:0]    gpio_out_i,
  input  wire [`IO_GPIO_W-1:0]    gpio_dir_i,
  output logic [`IO_GPIO_W-1:0]   gpio_in_o,
  // Pads
  inout  wire                     pad_spim_sck,
  inout  wire                     pad_spim_csn0,
  inout  wire                     pad_spim_sdio0,
  inout  wire                     pad_spim_sdio1,
  inout  wire [`IO_GPIO_W-1:0]    pad_gpio
);

  logic                  boot_req;
  logic                  boot_gnt;
  logic                  host_req;
  logic                  host_gnt;
  logic [`IO_GPIO_W-1:0] gpio_pad_out;
  logic [`IO_GPIO_W-1:0] gpio_pad_oe;
  logic [`IO_GPIO_W-1:0] gpio_pad_in;

  spi_pin_if boot_pins ();
  spi_pin_if host_pins ();
  spi_pin_if pad_pins ();

  spi_master u_boot_spim (
    .ref_clk_i (ref_clk_i),
    .rst_n_i   (rst_n_i),
    .start_i   (boot_start_i),
    .tx_data_i (boot_tx_i),
    .rx_data_o (boot_rx_o),
    .done_o    (boot_done_o),
    .busy_o    (boot_busy_o),
    .req_o     (boot_req),
    .gnt_i     (boot_gnt),
    .spi       (boot_pins.engine)
  );

  spi_master u_host_spim (
    .ref_clk_i (ref_clk_i),
    .rst_n_i   (rst_n_i),
    .start_i   (host_start_i),
    .tx_data_i (host_tx_i),
    .rx_data_o (host_rx_o),
    .done_o    (host_done_o),
    .busy_o    (host_busy_o),
    .req_o     (host_req),
    .gnt_i     (host_gnt),
    .spi       (host_pins.engine)
  );

  spi_pad_arbiter u_arb (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .boot_req_i (boot_req),
    .host_req_i (host_req),
    .boot_gnt_o (boot_gnt),
    .host_gnt_o (host_gnt),
    .boot_spi   (boot_pins.arb),
    .host_spi   (host_pins.arb),
    .pad_spi    (pad_pins.pad_src)
  );

  gpio_ctrl u_gpio (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .gpio_out_i (gpio_out_i),
    .gpio_dir_i (gpio_dir_i),
    .pad_out_o  (gpio_pad_out),
    .pad_oe_o   (gpio_pad_oe),
    .pad_in_i   (gpio_pad_in),
    .gpio_in_o  (gpio_in_o)
  );

  pad_frame u_pads (
    .spi            (pad_pins.pad),
    .pad_out_i      (gpio_pad_out),
    .pad_oe_i       (gpio_pad_oe),
    .pad_in_o       (gpio_pad_in),
    .pad_spim_sck   (pad_spim_sck),
    .pad_spim_csn0  (pad_spim_csn0),
    .pad_spim_sdio0 (pad_spim_sdio0),
    .pad_spim_sdio1 (pad_spim_sdio1),
    .pad_gpio       (pad_gpio)
  );

  // A low chip select pin always belongs to a busy engine that owns the pads
  a_csn_pad_owner: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    !pad_spim_csn0 |-> (u_arb.owner_q == OWN_BOOT && boot_busy_o) ||
                       (u_arb.owner_q == OWN_HOST && host_busy_o))
    else $error("chip select pad low without a busy owner");

endmodule

`default_nettype wire

/* design/gpio_ctrl.sv */
// ----------------------------------------------------------------------------
// GPIO drive toward the pad frame and input synchronizer back to the core
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "io_params.svh"

module gpio_ctrl (
  input  wire                   ref_clk_i,
  input  wire                   rst_n_i,
  input  wire [`IO_GPIO_W-1:0]  gpio_out_i,
  input  wire [`IO_GPIO_W-1:0]  gpio_dir_i,
  output logic [`IO_GPIO_W-1:0] pad_out_o,
  output logic [`IO_GPIO_W-1:0] pad_oe_o,
  input  wire [`IO_GPIO_W-1:0]  pad_in_i,
  output logic [`IO_GPIO_W-1:0] gpio_in_o
);

  logic [`IO_GPIO_W-1:0] sync1_q;
  logic [`IO_GPIO_W-1:0] sync2_q;

  // Direction 1 means output
  assign pad_out_o = gpio_out_i;
  assign pad_oe_o  = gpio_dir_i;

  // Pad levels are asynchronous to ref_clk
  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= pad_in_i;
      sync2_q <= sync1_q;
    end
  end

  assign gpio_in_o = sync2_q;

endmodule

`default_nettype wire

/* design/spi_pad_arbiter.sv */
// ----------------------------------------------------------------------------
// Owner of the shared SPI pads, one engine per frame, round robin on ties
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_pad_arbiter
  import io_pkg::*;
(
  input  wire         ref_clk_i,
  input  wire         rst_n_i,
  input  wire         boot_req_i,
  input  wire         host_req_i,
  output logic        boot_gnt_o,
  output logic        host_gnt_o,
  spi_pin_if.arb      boot_spi,
  spi_pin_if.arb      host_spi,
  spi_pin_if.pad_src  pad_spi
);

  pad_owner_e owner_q;
  // Boot engine won the last tie
  logic       last_boot_q;

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      owner_q     <= OWN_NONE;
      last_boot_q <= 1'b0;
    end else begin
      case (owner_q)
        OWN_NONE: begin
          if (boot_req_i && host_req_i) begin
            owner_q     <= last_boot_q ? OWN_HOST : OWN_BOOT;
            last_boot_q <= !last_boot_q;
          end else if (boot_req_i) begin
            owner_q <= OWN_BOOT;
          end else if (host_req_i) begin
            owner_q <= OWN_HOST;
          end
        end
        // Grant held until the frame ends and the request drops
        OWN_BOOT: if (!boot_req_i) owner_q <= OWN_NONE;
        OWN_HOST: if (!host_req_i) owner_q <= OWN_NONE;
        default:  owner_q <= OWN_NONE;
      endcase
    end
  end

  assign boot_gnt_o = (owner_q == OWN_BOOT);
  assign host_gnt_o = (owner_q == OWN_HOST);

  // Pin mux, idle pins when nobody owns the pads
  always_comb begin
    pad_spi.sck   = 1'b0;
    pad_spi.csn   = 1'b1;
    pad_spi.mosi  = 1'b0;
    boot_spi.miso = 1'b0;
    host_spi.miso = 1'b0;
    case (owner_q)
      OWN_BOOT: begin
        pad_spi.sck   = boot_spi.sck;
        pad_spi.csn   = boot_spi.csn;
        pad_spi.mosi  = boot_spi.mosi;
        boot_spi.miso = pad_spi.miso;
      end
      OWN_HOST: begin
        pad_spi.sck   = host_spi.sck;
        pad_spi.csn   = host_spi.csn;
        pad_spi.mosi  = host_spi.mosi;
        host_spi.miso = pad_spi.miso;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* design/spi_master.sv */
// ----------------------------------------------------------------------------
// Single-lane SPI master, mode 0, MSB first, one frame per start pulse
// Requests the shared pads from the arbiter before each frame
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "io_params.svh"

module spi_master
  import io_pkg::*;
(
  input  wire                    ref_clk_i,
  input  wire                    rst_n_i,
  input  wire                    start_i,
  input  wire [`IO_SPI_BITS-1:0] tx_data_i,
  output logic [`IO_SPI_BITS-1:0] rx_data_o,
  output logic                   done_o,
  output logic                   busy_o,
  output logic                   req_o,
  input  wire                    gnt_i,
  spi_pin_if.engine              spi
);

  localparam int BITS  = `IO_SPI_BITS;
  localparam int DIV   = `IO_SPI_DIV;
  localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;
  localparam int BIT_W = (BITS > 1) ? $clog2(BITS) : 1;

  spi_state_e       state_q;
  logic [DIV_W-1:0] div_q;
  logic [BIT_W-1:0] bit_q;
  logic [BITS-1:0]  tx_q;
  logic [BITS-1:0]  rx_q;
  logic             div_end;

  // Last reference cycle of an SCK half period
  assign div_end = (div_q == DIV_W'(DIV - 1));

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      div_q   <= '0;
      bit_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          // Starts while busy never reach this state
          if (start_i) state_q <= REQ;
        end
        REQ: begin
          if (gnt_i) state_q <= LEAD;
        end
        LEAD: begin
          state_q <= SCK_LO;
          div_q   <= '0;
          bit_q   <= '0;
        end
        SCK_LO: begin
          if (div_end) begin
            div_q   <= '0;
            state_q <= SCK_HI;
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        SCK_HI: begin
          if (div_end) begin
            div_q <= '0;
            if (bit_q == BIT_W'(BITS - 1)) begin
              state_q <= TRAIL;
            end else begin
              bit_q   <= bit_q + 1'b1;
              state_q <= SCK_LO;
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        TRAIL: begin
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Shift registers, MOSI moves on falling SCK, MISO captured on rising SCK
  always_ff @(posedge ref_clk_i) begin
    if (state_q == IDLE && start_i) begin
      tx_q <= tx_data_i;
    end else if (state_q == SCK_HI && div_end) begin
      tx_q <= {tx_q[BITS-2:0], 1'b0};
    end
    if (state_q == SCK_LO && div_end) begin
      rx_q <= {rx_q[BITS-2:0], spi.miso};
    end
  end

  assign spi.sck  = (state_q == SCK_HI);
  assign spi.csn  = !(state_q inside {LEAD, SCK_LO, SCK_HI});
  assign spi.mosi = tx_q[BITS-1];

  assign req_o     = (state_q inside {REQ, LEAD, SCK_LO, SCK_HI});
  assign busy_o    = (state_q != IDLE);
  assign done_o    = (state_q == TRAIL);
  assign rx_data_o = rx_q;

  // Chip select may only go low on pads this engine was granted
  a_csn_needs_gnt: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    !spi.csn |-> gnt_i)
    else $error("chip select low without grant");

endmodule

`default_nettype wire

/* design/pad_frame.sv */
// ----------------------------------------------------------------------------
// Pad ring for the shared SPI pins and the GPIO bank
// SPI pads are pulled down, GPIO pads are pulled up
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "io_params.svh"

module pad_frame (
  // SPI pins from the arbiter
  spi_pin_if.pad                spi,

  // GPIO core side
  input  wire [`IO_GPIO_W-1:0]  pad_out_i,
  input  wire [`IO_GPIO_W-1:0]  pad_oe_i,
  output logic [`IO_GPIO_W-1:0] pad_in_o,

  // SPI master pads
  inout  wire                   pad_spim_sck,
  inout  wire                   pad_spim_csn0,
  inout  wire                   pad_spim_sdio0,
  inout  wire                   pad_spim_sdio1,

  // GPIO pads
  inout  wire [`IO_GPIO_W-1:0]  pad_gpio
);

  // SPI outputs, always driven
  pad_cell #(.PULL_UP(1'b0)) padinst_spim_sck (
    .oen_i  (1'b0),
    .data_i (spi.sck),
    .data_o (),
    .pen_i  (1'b1),
    .pad    (pad_spim_sck)
  );

  pad_cell #(.PULL_UP(1'b0)) padinst_spim_csn0 (
    .oen_i  (1'b0),
    .data_i (spi.csn),
    .data_o (),
    .pen_i  (1'b1),
    .pad    (pad_spim_csn0)
  );

  pad_cell #(.PULL_UP(1'b0)) padinst_spim_sdio0 (
    .oen_i  (1'b0),
    .data_i (spi.mosi),
    .data_o (),
    .pen_i  (1'b1),
    .pad    (pad_spim_sdio0)
  );

  // MISO, input only
  pad_cell #(.PULL_UP(1'b0)) padinst_spim_sdio1 (
    .oen_i  (1'b1),
    .data_i (1'b0),
    .data_o (spi.miso),
    .pen_i  (1'b1),
    .pad    (pad_spim_sdio1)
  );

  // GPIO bank, direction bit 1 drives the pad
  genvar i;
  generate
    for (i = 0; i < `IO_GPIO_W; i++) begin : g_gpio
      pad_cell #(.PULL_UP(1'b1)) padinst_gpio (
        .oen_i  (~pad_oe_i[i]),
        .data_i (pad_out_i[i]),
        .data_o (pad_in_o[i]),
        .pen_i  (1'b1),
        .pad    (pad_gpio[i])
      );
    end
  endgenerate

endmodule

`default_nettype wire

/* design/pad_cell.sv */
// ----------------------------------------------------------------------------
// Behavioural bidirectional pad, active-low output enable and weak pull
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pad_cell #(
  // 1 pulls the pad up, 0 pulls it down
  parameter bit PULL_UP = 1'b1
) (
  input  wire  oen_i,
  input  wire  data_i,
  output logic data_o,
  input  wire  pen_i,
  inout  wire  pad
);

  // Strong drive while the output is enabled
  assign pad = oen_i ? 1'bz : data_i;

  // Pull only wins when nobody drives the pad
  assign (pull1, pull0) pad = pen_i ? PULL_UP : 1'bz;

  // Pad level back to the core, also when driving
  assign data_o = pad;

endmodule

`default_nettype wire

/* design/spi_pin_if.sv */
// ----------------------------------------------------------------------------
// Single-lane SPI pin bundle between an engine, the arbiter and the pads
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface spi_pin_if;

  logic sck;
  logic csn;
  logic mosi;
  logic miso;

  // SPI engine side
  modport engine (output sck, output csn, output mosi, input miso);

  // Arbiter side facing one engine
  modport arb (input sck, input csn, input mosi, output miso);

  // Arbiter side driving the pad frame
  modport pad_src (output sck, output csn, output mosi, input miso);

  // Pad frame side
  modport pad (input sck, input csn, input mosi, output miso);

endinterface

`default_nettype wire

/* design/io_pkg.sv */
// ----------------------------------------------------------------------------
// Shared types for the SPI engines and the pad arbiter
// ----------------------------------------------------------------------------
`default_nettype none

package io_pkg;

  // SPI master engine states
  typedef enum logic [2:0] {
    IDLE,    // waiting for start
    REQ,     // pads requested, waiting for grant
    LEAD,    // chip select low, first bit on MOSI
    SCK_LO,  // low half of a bit
    SCK_HI,  // high half of a bit
    TRAIL    // chip select high, done pulse
  } spi_state_e;

  // Current holder of the shared SPI pads
  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_BOOT,
    OWN_HOST
  } pad_owner_e;

endpackage

`default_nettype wire

/* design/io_params.svh */
// ----------------------------------------------------------------------------
// Size and timing constants for the I/O subsystem, included by the RTL files
// ----------------------------------------------------------------------------
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// Number of GPIO pads in the pad frame
`define IO_GPIO_W 8

// SPI frame length in bits, single lane, MSB first
`define IO_SPI_BITS 8

// Reference clock cycles per SCK half period
// A full SCK period is twice this value
`define IO_SPI_DIV 2

`endif
